/* hdl/cpu_pkg.sv */
package cpu_pkg;

    // data word and bus address width
    localparam int word_w = 16;
    // address field of an instruction word
    localparam int addr_w = 12;
    // major opcode field in the top bits
    localparam int opc_w = 4;

    // major opcodes
    // anything not listed here decodes as nop
    localparam logic [3:0] op_nop  = 4'h0;
    localparam logic [3:0] op_lda  = 4'h1;
    localparam logic [3:0] op_sta  = 4'h2;
    localparam logic [3:0] op_jmp  = 4'h3;
    localparam logic [3:0] op_jz   = 4'h4;
    localparam logic [3:0] op_halt = 4'h5;
    localparam logic [3:0] op_alu  = 4'h6;

    // alu operation select, held in ir[11:8] of an alu instruction
    // arithmetic
    localparam logic [3:0] alu_add  = 4'd0;
    localparam logic [3:0] alu_sub  = 4'd1;
    localparam logic [3:0] alu_mul  = 4'd2;
    localparam logic [3:0] alu_div  = 4'd3;
    // single bit shifts and rotates of operand a
    localparam logic [3:0] alu_shl  = 4'd4;
    localparam logic [3:0] alu_shr  = 4'd5;
    localparam logic [3:0] alu_rol  = 4'd6;
    localparam logic [3:0] alu_ror  = 4'd7;
    // bitwise logic
    localparam logic [3:0] alu_and  = 4'd8;
    localparam logic [3:0] alu_or   = 4'd9;
    localparam logic [3:0] alu_xor  = 4'd10;
    localparam logic [3:0] alu_nor  = 4'd11;
    localparam logic [3:0] alu_nand = 4'd12;
    localparam logic [3:0] alu_xnor = 4'd13;
    // compares, result is one or zero
    localparam logic [3:0] alu_gt   = 4'd14;
    localparam logic [3:0] alu_eq   = 4'd15;

    // control fsm states
    // instruction fetch bus read at pc
    localparam logic [2:0] st_fetch     = 3'd0;
    // one cycle to look at the fresh ir
    localparam logic [2:0] st_decode    = 3'd1;
    // operand bus read for lda and alu
    localparam logic [2:0] st_operand   = 3'd2;
    // accumulator bus write for sta
    localparam logic [2:0] st_store     = 3'd3;
    // accumulator update from mdr or alu
    localparam logic [2:0] st_writeback = 3'd4;
    // parked until reset
    localparam logic [2:0] st_halt      = 3'd5;

endpackage

/* hdl/alu.sv */
`timescale 1ns/10ps

module alu
    import cpu_pkg::*;
(
    input  logic [word_w-1:0] operand_a,
    input  logic [word_w-1:0] operand_b,
    input  logic [3:0]        alu_op,
    output logic [word_w-1:0] result
);

    // product truncated to the low word
    logic [word_w-1:0] product;
    logic [word_w-1:0] quotient;

    assign product = operand_a * operand_b;

    // divide by zero gives all ones
    assign quotient = (operand_b == '0) ? '1 : operand_a / operand_b;

    always_comb begin
        case (alu_op)
            alu_add:  result = operand_a + operand_b;
            alu_sub:  result = operand_a - operand_b;
            alu_mul:  result = product;
            alu_div:  result = quotient;
            // shifts fill with zero
            alu_shl:  result = {operand_a[word_w-2:0], 1'b0};
            alu_shr:  result = {1'b0, operand_a[word_w-1:1]};
            // rotates by one place
            alu_rol:  result = {operand_a[word_w-2:0], operand_a[word_w-1]};
            alu_ror:  result = {operand_a[0], operand_a[word_w-1:1]};
            alu_and:  result = operand_a & operand_b;
            alu_or:   result = operand_a | operand_b;
            alu_xor:  result = operand_a ^ operand_b;
            alu_nor:  result = ~(operand_a | operand_b);
            alu_nand: result = ~(operand_a & operand_b);
            alu_xnor: result = ~(operand_a ^ operand_b);
            // unsigned compares
            alu_gt: begin
                result = (operand_a > operand_b) ? word_w'(1) : '0;
            end
            alu_eq: begin
                result = (operand_a == operand_b) ? word_w'(1) : '0;
            end
            default:  result = '0;
        endcase
    end

endmodule

/* hdl/program_counter.sv */
`timescale 1ns/10ps

module program_counter
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              pc_inc,
    input  logic              pc_load,
    input  logic [addr_w-1:0] jump_addr,
    output logic [word_w-1:0] pc
);

    // jump target widened to the bus address
    logic [word_w-1:0] jump_target;

    assign jump_target = {{(word_w-addr_w){1'b0}}, jump_addr};

    // load wins over increment
    // increment wraps from all ones back to zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= jump_target;
        end else if (pc_inc) begin
            pc <= pc + word_w'(1);
        end
    end

endmodule

/* hdl/cpu_control_fsm.sv */
`timescale 1ns/10ps

module cpu_control_fsm
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic [opc_w-1:0] opcode,
    input  logic             acc_zero,
    input  logic             wb_ack,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic             pc_inc,
    output logic             pc_load,
    output logic             ir_load,
    output logic             mdr_load,
    output logic             acc_load,
    output logic             acc_sel,
    output logic             adr_sel,
    output logic             halted
);

    logic [2:0] state;
    logic [2:0] state_nxt;
    logic       stb_q;
    logic       stb_nxt;
    // state owns the bus this cycle
    logic       bus_state;
    // bus access completes on this edge
    logic       bus_done;

    assign bus_state = (state == st_fetch) || (state == st_operand) || (state == st_store);
    assign bus_done  = stb_q && wb_ack;

    // classic single access with cyc and stb moving together
    assign wb_cyc = stb_q;
    assign wb_stb = stb_q;
    // only the store state writes
    assign wb_we  = (state == st_store);

    // strobe rises one cycle into a bus state
    // drops on the ack edge and stays low at least a cycle between accesses
    always_comb begin
        if (!bus_state) begin
            stb_nxt = 1'b0;
        end else if (stb_q) begin
            stb_nxt = !wb_ack;
        end else begin
            stb_nxt = 1'b1;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_fetch: begin
                if (bus_done) begin
                    state_nxt = st_fetch;
                    state_nxt = st_decode;
                end
            end
            st_decode: begin
                case (opcode)
                    op_lda, op_alu: state_nxt = st_operand;
                    op_sta:         state_nxt = st_store;
                    op_halt:        state_nxt = st_halt;
                    // nop, jumps and unknown opcodes go back to fetch
                    // jumps load pc here
                    default:        state_nxt = st_fetch;
                endcase
            end
            st_operand: begin
                if (bus_done) begin
                    state_nxt = st_writeback;
                end
            end
            st_store: begin
                if (bus_done) begin
                    state_nxt = st_fetch;
                end
            end
            st_writeback: state_nxt = st_fetch;
            st_halt:      state_nxt = st_halt;
            default:      state_nxt = st_fetch;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_fetch;
            stb_q <= 1'b0;
        end else begin
            state <= state_nxt;
            stb_q <= stb_nxt;
        end
    end

    // fetch ack captures the instruction and steps pc
    assign ir_load = (state == st_fetch) && bus_done;
    assign pc_inc  = (state == st_fetch) && bus_done;

    // jz is taken only on a zero accumulator
    assign pc_load = (state == st_decode) &&
                     ((opcode == op_jmp) || ((opcode == op_jz) && acc_zero));

    assign mdr_load = (state == st_operand) && bus_done;
    assign acc_load = (state == st_writeback);
    // high picks the alu result and low the mdr
    assign acc_sel  = (opcode == op_alu);
    // high puts the operand address on the bus
    assign adr_sel  = (state == st_operand) || (state == st_store);
    assign halted   = (state == st_halt);

endmodule

/* hdl/cpu_datapath.sv */
`timescale 1ns/10ps

module cpu_datapath
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              ir_load,
    input  logic              mdr_load,
    input  logic              acc_load,
    input  logic              acc_sel,
    input  logic              adr_sel,
    input  logic [word_w-1:0] pc,
    input  logic [word_w-1:0] wb_dat_r,
    input  logic [word_w-1:0] alu_result,
    output logic [opc_w-1:0]  opcode,
    output logic [3:0]        alu_op,
    output logic [addr_w-1:0] jump_addr,
    output logic [word_w-1:0] acc,
    output logic [word_w-1:0] mdr,
    output logic              acc_zero,
    output logic [word_w-1:0] wb_adr,
    output logic [word_w-1:0] wb_dat_w
);

    logic [word_w-1:0] ir;
    // operand address of the current instruction
    logic [word_w-1:0] operand_adr;
    logic [word_w-1:0] acc_nxt;

    // instruction fields
    assign opcode    = ir[word_w-1:word_w-opc_w];
    assign alu_op    = ir[addr_w-1:addr_w-4];
    assign jump_addr = ir[addr_w-1:0];

    // alu class addresses page zero through the low byte
    // lda and sta use the full 12 bit field
    always_comb begin
        if (opcode == op_alu) begin
            operand_adr = {{(word_w-8){1'b0}}, ir[7:0]};
        end else begin
            operand_adr = {{(word_w-addr_w){1'b0}}, ir[addr_w-1:0]};
        end
    end

    // bus address mux
    assign wb_adr = adr_sel ? operand_adr : pc;

    // store data is always the accumulator
    assign wb_dat_w = acc;

    assign acc_zero = (acc == '0);

    // accumulator source, mdr for lda or alu result
    assign acc_nxt = acc_sel ? alu_result : mdr;

    // instruction register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= wb_dat_r;
        end
    end

    // memory data register, holds the read operand
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mdr <= '0;
        end else if (mdr_load) begin
            mdr <= wb_dat_r;
        end
    end

    // accumulator
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (acc_load) begin
            acc <= acc_nxt;
        end
    end

endmodule

/* hdl/accumulator_cpu.sv */
`timescale 1ns/10ps

module accumulator_cpu
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    // wishbone classic master
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output logic [word_w-1:0] wb_adr,
    output logic [word_w-1:0] wb_dat_w,
    input  logic [word_w-1:0] wb_dat_r,
    input  logic              wb_ack,
    output logic              halted
);

    // fsm to counter and datapath
    logic pc_inc;
    logic pc_load;
    logic ir_load;
    logic mdr_load;
    logic acc_load;
    logic acc_sel;
    logic adr_sel;

    // datapath back to fsm, counter and alu
    logic [opc_w-1:0]  opcode;
    logic [3:0]        alu_op;
    logic [addr_w-1:0] jump_addr;
    logic              acc_zero;
    logic [word_w-1:0] acc;
    logic [word_w-1:0] mdr;
    logic [word_w-1:0] alu_result;
    logic [word_w-1:0] pc;

    cpu_control_fsm u_fsm (
        .clk(clk), .arst_n(arst_n),
        .opcode(opcode), .acc_zero(acc_zero), .wb_ack(wb_ack),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .pc_inc(pc_inc), .pc_load(pc_load),
        .ir_load(ir_load), .mdr_load(mdr_load), .acc_load(acc_load),
        .acc_sel(acc_sel), .adr_sel(adr_sel), .halted(halted)
    );

    program_counter u_pc (
        .clk(clk), .arst_n(arst_n),
        .pc_inc(pc_inc), .pc_load(pc_load), .jump_addr(jump_addr), .pc(pc)
    );

    cpu_datapath u_dp (
        .clk(clk), .arst_n(arst_n),
        .ir_load(ir_load), .mdr_load(mdr_load), .acc_load(acc_load),
        .acc_sel(acc_sel), .adr_sel(adr_sel),
        .pc(pc), .wb_dat_r(wb_dat_r), .alu_result(alu_result),
        .opcode(opcode), .alu_op(alu_op), .jump_addr(jump_addr),
        .acc(acc), .mdr(mdr), .acc_zero(acc_zero),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w)
    );

    // accumulator is operand a, memory word operand b
    alu u_alu (
        .operand_a(acc), .operand_b(mdr), .alu_op(alu_op), .result(alu_result)
    );

endmodule

/* verification/tb_accumulator_cpu.sv */
`timescale 1ns/10ps

module tb_accumulator_cpu;

    localparam int mem_words     = 4096;
    // expected results sit above the memory image in the golden file
    localparam int golden_base   = 4096;
    localparam int golden_words  = 8192;
    localparam int fetch_timeout = 32;
    localparam int halt_timeout  = 20000;
    // cycles watched after halt for a stray bus access
    localparam int quiet_cycles  = 64;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic        wb_ack;
    logic        halted;

    logic [15:0] golden_img [0:golden_words-1];
    logic [15:0] mem [0:mem_words-1];

    // expected outcome, taken from the golden file
    int          exp_count;
    logic [15:0] halt_adr;
    // progress of the memory slave
    int          store_idx;
    logic [15:0] last_read_adr;

    // slave state
    logic [31:0] rng_state;
    logic        active;
    logic [1:0]  delay_cnt;
    logic [11:0] mem_index;
    logic        done_last;
    // bus values latched when a strobe begins
    logic        hold_valid;
    logic [15:0] hold_adr;
    logic        hold_we;
    logic [15:0] hold_dat;

    int value_errors   = 0;
    int other_errors   = 0;
    int timeout_errors = 0;

    accumulator_cpu UUT (
        .clk(clk), .arst_n(arst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack), .halted(halted)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%04h, expected 0x%04h", name, got, expected);
            value_errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR: %s", msg);
        other_errors++;
    endtask

    task automatic report_timeout(input string msg);
        $display("TIMEOUT: %s", msg);
        timeout_errors++;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // wishbone memory slave with 0 to 3 cycles of random ack delay
    initial begin
        wb_ack = 1'b0;
        wb_dat_r = 16'h0000;
        rng_state = 32'he047_4a43;
        active = 1'b0;
        delay_cnt = 2'd0;
        mem_index = 12'h000;
        done_last = 1'b0;
        hold_valid = 1'b0;
        hold_adr = 16'h0000;
        hold_we = 1'b0;
        hold_dat = 16'h0000;
        store_idx = 0;
        last_read_adr = 16'hffff;
        // fill first, so unwritten words still differ per address
        for (int i = 0; i < golden_words; i++) begin
            golden_img[i] = 16'(i) ^ 16'h5a5a;
        end
        $readmemh("verification/cpu_golden.mem", golden_img);
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = golden_img[i];
        end
        exp_count = int'(golden_img[golden_base]);
        halt_adr = golden_img[golden_base + 1 + 2 * exp_count];
        forever begin
            @(posedge clk);
            if (!arst_n) begin
                wb_ack <= 1'b0;
                active = 1'b0;
                hold_valid = 1'b0;
                done_last = 1'b0;
            end else begin
                check_value("wb_cyc", 16'(wb_cyc), 16'(wb_stb));
                // strobe must drop in the cycle after ack
                if (done_last && wb_stb) begin
                    report_problem("wb_stb still high in the cycle after ack");
                end
                done_last = wb_stb && wb_ack;
                // address, direction and write data held until ack
                if (wb_stb) begin
                    if (hold_valid) begin
                        check_value("wb_adr", wb_adr, hold_adr);
                        check_value("wb_we", 16'(wb_we), 16'(hold_we));
                        check_value("wb_dat_w", wb_dat_w, hold_dat);
                    end else begin
                        hold_adr = wb_adr;
                        hold_we = wb_we;
                        hold_dat = wb_dat_w;
                        hold_valid = 1'b1;
                    end
                end
                if (wb_stb && wb_ack) begin
                    hold_valid = 1'b0;
                end
                wb_ack <= 1'b0;
                if (wb_stb && !wb_ack) begin
                    if (!active) begin
                        rng_state = xorshift32(rng_state);
                        delay_cnt = rng_state[1:0];
                        active = 1'b1;
                    end
                    if (delay_cnt == 2'd0) begin
                        active = 1'b0;
                        mem_index = wb_adr[11:0];
                        if (wb_adr[15:12] != 4'h0) begin
                            report_problem("bus address outside the 4096 word memory");
                        end
                        if (wb_we) begin
                            mem[mem_index] = wb_dat_w;
                            // stores compared in bus order
                            if (store_idx < exp_count) begin
                                check_value("store wb_adr", wb_adr,
                                            golden_img[golden_base + 1 + 2 * store_idx]);
                                check_value("store wb_dat_w", wb_dat_w,
                                            golden_img[golden_base + 2 + 2 * store_idx]);
                            end else begin
                                report_problem("store beyond the expected list");
                            end
                            store_idx++;
                        end else begin
                            wb_dat_r <= mem[mem_index];
                            last_read_adr = wb_adr;
                        end
                        wb_ack <= 1'b1;
                    end else begin
                        delay_cnt = delay_cnt - 2'd1;
                    end
                end
            end
        end
    end

    initial begin
        logic found;
        int   cycles;
        arst_n = 1'b0;
        found = 1'b0;
        repeat (16) @(posedge clk);
        // idle bus while reset is held
        check_value("wb_cyc", 16'(wb_cyc), 16'h0000);
        check_value("wb_stb", 16'(wb_stb), 16'h0000);
        check_value("halted", 16'(halted), 16'h0000);
        arst_n <= 1'b1;

        // first access is an instruction read at zero
        cycles = 0;
        while (!found && cycles < fetch_timeout) begin
            @(posedge clk);
            cycles++;
            found = wb_stb;
        end
        if (found) begin
            check_value("first wb_adr", wb_adr, 16'h0000);
            check_value("first wb_we", 16'(wb_we), 16'h0000);
        end else begin
            report_timeout("no bus access started after reset");
        end

        if (found) begin
            found = 1'b0;
            cycles = 0;
            while (!found && cycles < halt_timeout) begin
                @(posedge clk);
                cycles++;
                found = halted;
            end
            if (found) begin
                // last read before halt is the halt fetch
                check_value("halt fetch wb_adr", last_read_adr, halt_adr);
                check_value("store count", 16'(store_idx), 16'(exp_count));
                cycles = 0;
                while (cycles < quiet_cycles) begin
                    @(posedge clk);
                    cycles++;
                    if (wb_cyc || wb_stb) begin
                        report_problem("a bus cycle started after halt");
                    end
                    if (!halted) begin
                        report_problem("halted dropped without a reset");
                    end
                end
            end else begin
                report_timeout("the core never raised halted");
            end
        end

        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, other_errors, timeout_errors);
        if (value_errors == 0 && other_errors == 0 && timeout_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verification/cpu_golden.mem */
// hex words: program and data image in 0x000-0xfff, then from 0x1000
// the store count, store address/data pairs in order, and the halt fetch address
@000
10C0 60C1 2100 // add a+b
10C1 61C0 2101 // sub b-a
10C0 62C1 2102 // mul a*b, low half
10C0 63C1 2103 // div a/b
10C0 63C2 2104 // div a/0
10C3 64C1 2105 // shl h
10C3 65C1 2106 // shr h
10C3 66C1 2107 // rol h
10C3 67C1 2108 // ror h
10C0 68C4 2109 // and a,d
10C0 69C4 210A // or a,d
10C0 6AC4 210B // xor a,d
10C0 6BC4 210C // nor a,d
10C0 6CC4 210D // nand a,d
10C0 6DC4 210E // xnor a,d
10C0 6EC1 210F // gt a>b true
10C1 6EC0 2110 // gt b>a false
10C0 6FC0 2111 // eq a==a true
10C0 6FC1 2112 // eq a==b false
1300 2200 // lda beyond page zero, sta to 0x200
303E 10C0 22FF // jmp over a load and a store
10C0 404A 2201 // acc nonzero, jz not taken
10C2 4045 22FF 22FF // acc zero, jz taken over two stores
2202 0000 F123 7ABC // store zero, nop, two unknown opcodes
5000 // halt at 0x049
22FF 5000 // wrong path of the jz at 0x03f
@0C0
1234 0056 0000 8001 F00F // operands a, b, zero, h, d
@300
C0DE
@1000
0016 // number of expected stores
0100 128A 0101 EE22
0102 1D78 0103 0036
0104 FFFF 0105 0002
0106 4000 0107 0003
0108 C000 0109 1004
010A F23F 010B E23B
010C 0DC0 010D EFFB
010E 1DC4 010F 0001
0110 0000 0111 0001
0112 0000 0200 C0DE
0201 1234 0202 0000
0049 // fetch address of the halt

/* sources.f */
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/program_counter.sv
hdl/cpu_control_fsm.sv
hdl/cpu_datapath.sv
hdl/accumulator_cpu.sv
verification/tb_accumulator_cpu.sv

/* Makefile */
# Verilator build and run of the accumulator CPU testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_accumulator_cpu
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
FAIL_MSG  ?= SOME TESTS FAILED
PASS_MSG  ?= ALL TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation incomplete, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
